//--- include/mcd_config.svh
`ifndef MCD_CONFIG_SVH
`define MCD_CONFIG_SVH

// communication word banks
`define MCD_COM_WORDS        8

// sub clock is clk_asic divided by 2**bits
`define MCD_CLK_DIV_BITS     2

// byte offsets inside the gate array register window
`define MCD_OFS_CTRL         9'h000    // main side
`define MCD_OFS_HINT         9'h006    // main side
`define MCD_OFS_FLAG         9'h00E    // both sides
`define MCD_OFS_CMD_BASE     9'h010    // command words
`define MCD_OFS_STA_BASE     9'h020    // status words
`define MCD_OFS_LED          9'h000    // sub side

// hint vector comes up as all ones
`define MCD_HINT_RESET       16'hFFFF

// what each side sees on an offset nothing decodes
`define MCD_MAIN_UNMAPPED    16'hFFFF
`define MCD_SUB_UNMAPPED     16'h0000

`endif

//--- verilog/mcd_pkg.sv
package mcd_pkg;

	// one bus data word
	typedef logic [15:0] mcd_word_t;

	// register byte offset, bit 0 always zero
	typedef logic [8:0] mcd_ofs_t;

	// one side's register access as seen on its pins
	typedef struct packed
	{
		mcd_ofs_t  ofs;      // byte offset in the register window
		mcd_word_t wdata;
		logic      we_lo;    // low byte strobe
		logic      we_hi;    // high byte strobe
		logic      ce;       // register block select
	} mcd_bus_t;

	// write pulse after strobe synchronisation
	typedef struct packed
	{
		mcd_ofs_t   ofs;
		mcd_word_t  wdata;
		logic [1:0] lane;    // bit 1 high byte, bit 0 low byte
		logic       valid;   // one clock, always on a sub tick
	} mcd_wr_t;

	// control lines toward the sub CPU
	typedef struct packed
	{
		logic sub_reset;     // held while main keeps the reset bit clear
		logic sub_bus_req;
		logic irq2;          // level 2 interrupt trigger
	} mcd_ctrl_t;

endpackage

//--- verilog/mcd_sub_clk_en.sv
`include "mcd_config.svh"

module mcd_sub_clk_en
(
	input  logic clk_asic,
	input  logic cd_rst,
	input  logic cd_halt,
	output logic sub_sync
);

	logic [`MCD_CLK_DIV_BITS-1:0] div_cnt;    // free running

	always_ff @(posedge clk_asic or posedge cd_rst)
	begin
		if (cd_rst)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// tick on the last count unless halted
	assign sub_sync = (&div_cnt) & ~cd_halt;

	// halt gates every tick
	assert property (@(posedge clk_asic) disable iff (cd_rst)
		!$isunknown(cd_halt))
		else $error("cd_halt is unknown");

endmodule

//--- verilog/mcd_bus_port.sv
module mcd_bus_port
(
	input  logic              clk_asic,
	input  logic              cd_rst,
	input  logic              sub_sync,
	input  mcd_pkg::mcd_bus_t bus,
	output mcd_pkg::mcd_wr_t  wr
);
	import mcd_pkg::*;

	logic [1:0] strobe;      // lanes qualified by ce
	logic [1:0] smp_now;     // sampled on the latest tick
	logic [1:0] smp_prev;    // sampled on the tick before
	mcd_ofs_t   ofs_q;
	mcd_word_t  wdata_q;

	assign strobe = {bus.we_hi, bus.we_lo} & {2{bus.ce}};

	// two tick history of the strobes
	always_ff @(posedge clk_asic or posedge cd_rst)
	begin
		if (cd_rst)
		begin
			smp_now  <= 2'b00;
			smp_prev <= 2'b00;
		end
		else if (sub_sync)
		begin
			smp_now  <= strobe;
			smp_prev <= smp_now;
		end
	end

	// address and data taken together with the strobe sample
	always_ff @(posedge clk_asic)
	begin
		if (sub_sync)
		begin
			ofs_q   <= bus.ofs;
			wdata_q <= bus.wdata;
		end
	end

	// A held strobe stays in smp_prev after the first pulse, so it writes
	// once. It has to be seen released on a tick before the next access.
	assign wr.ofs   = ofs_q;
	assign wr.wdata = wdata_q;
	assign wr.lane  = smp_now;
	assign wr.valid = sub_sync & (smp_now != 2'b00) & (smp_prev == 2'b00);

	assert property (@(posedge clk_asic) disable iff (cd_rst)
		wr.valid |-> !wr.ofs[0])
		else $error("write pulse to an odd byte offset");

	assert property (@(posedge clk_asic) disable iff (cd_rst)
		(strobe != 2'b00 && $past(strobe) != 2'b00) |-> $stable({bus.ofs, bus.wdata}))
		else $error("offset or data changed while a strobe was held");

endmodule

//--- verilog/mcd_com_bank.sv
`include "mcd_config.svh"

module mcd_com_bank
#(
	parameter mcd_pkg::mcd_ofs_t BASE = `MCD_OFS_CMD_BASE
)
(
	input  logic               clk_asic,
	input  logic               cd_rst,
	input  mcd_pkg::mcd_wr_t   wr,
	input  mcd_pkg::mcd_ofs_t  rd_ofs,
	output logic               hit,
	output mcd_pkg::mcd_word_t rdata
);
	import mcd_pkg::*;

	localparam int       IDX_W = $clog2(`MCD_COM_WORDS);
	localparam mcd_ofs_t SPAN  = mcd_ofs_t'(2 * `MCD_COM_WORDS);    // bytes covered

	mcd_word_t        words [`MCD_COM_WORDS];
	mcd_ofs_t         wr_rel;
	mcd_ofs_t         rd_rel;
	logic             wr_hit;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;

	// offsets below BASE wrap to large values and miss
	assign wr_rel = wr.ofs - BASE;
	assign rd_rel = rd_ofs - BASE;

	assign wr_hit = wr_rel < SPAN;
	assign wr_idx = wr_rel[IDX_W:1];    // word index, byte bit dropped
	assign rd_idx = rd_rel[IDX_W:1];

	always_ff @(posedge clk_asic or posedge cd_rst)
	begin
		if (cd_rst)
		begin
			for (int i = 0; i < `MCD_COM_WORDS; i++)
				words[i] <= '0;
		end
		else if (wr.valid && wr_hit)
		begin
			if (wr.lane[0])
				words[wr_idx][7:0] <= wr.wdata[7:0];
			if (wr.lane[1])
				words[wr_idx][15:8] <= wr.wdata[15:8];
		end
	end

	// combinational read, the register map adds the flop
	assign hit   = rd_rel < SPAN;
	assign rdata = words[rd_idx];

endmodule

//--- verilog/mcd_gate_regs.sv
`include "mcd_config.svh"

module mcd_gate_regs
(
	input  logic                     clk_asic,
	input  logic                     cd_rst,
	input  mcd_pkg::mcd_wr_t         main_wr,
	input  mcd_pkg::mcd_wr_t         sub_wr,
	input  mcd_pkg::mcd_ofs_t        main_ofs,
	input  mcd_pkg::mcd_ofs_t        sub_ofs,
	input  logic [1:0]               cmd_hit,      // [0] main offset, [1] sub offset
	input  mcd_pkg::mcd_word_t [1:0] cmd_rdata,
	input  logic [1:0]               sta_hit,      // same order as cmd
	input  mcd_pkg::mcd_word_t [1:0] sta_rdata,
	output mcd_pkg::mcd_word_t       main_rdata,
	output mcd_pkg::mcd_word_t       sub_rdata,
	output mcd_pkg::mcd_ctrl_t       ctrl,
	output logic [1:0]               led,
	output mcd_pkg::mcd_word_t       hint
);
	import mcd_pkg::*;

	logic       sres_q;          // 1 lets the sub CPU run
	logic       sbrq_q;          // main asks for the sub bus
	logic       irq2_q;
	mcd_word_t  hint_q;
	logic [7:0] flag_main_q;     // high byte of the flag word
	logic [7:0] flag_sub_q;      // low byte
	logic [1:0] led_q;
	logic       main_ctrl_we;
	logic       main_hint_we;
	logic       main_flag_we;
	logic       sub_led_we;
	logic       sub_flag_we;
	mcd_word_t  flag_word;
	mcd_word_t  main_map;
	mcd_word_t  sub_map;

	assign main_ctrl_we = main_wr.valid && main_wr.ofs == `MCD_OFS_CTRL;
	assign main_hint_we = main_wr.valid && main_wr.ofs == `MCD_OFS_HINT;
	assign main_flag_we = main_wr.valid && main_wr.ofs == `MCD_OFS_FLAG;
	assign sub_led_we   = sub_wr.valid && sub_wr.ofs == `MCD_OFS_LED;
	assign sub_flag_we  = sub_wr.valid && sub_wr.ofs == `MCD_OFS_FLAG;

	always_ff @(posedge clk_asic or posedge cd_rst)
	begin
		if (cd_rst)
		begin
			sres_q      <= 1'b0;
			sbrq_q      <= 1'b0;
			irq2_q      <= 1'b0;
			hint_q      <= `MCD_HINT_RESET;
			flag_main_q <= 8'h00;
			flag_sub_q  <= 8'h00;
			led_q       <= 2'b00;
		end
		else
		begin
			// single clock, the write pulse is one clock wide
			irq2_q <= main_ctrl_we & main_wr.lane[1] & main_wr.wdata[8];
			if (main_ctrl_we && main_wr.lane[0])
			begin
				sres_q <= main_wr.wdata[0];
				sbrq_q <= main_wr.wdata[1];
			end
			if (main_hint_we && main_wr.lane[0])
				hint_q[7:0] <= main_wr.wdata[7:0];
			if (main_hint_we && main_wr.lane[1])
				hint_q[15:8] <= main_wr.wdata[15:8];
			if (main_flag_we)
				flag_main_q <= main_wr.wdata[15:8];    // either lane, own byte only
			if (sub_flag_we)
				flag_sub_q <= sub_wr.wdata[7:0];
			if (sub_led_we && sub_wr.lane[1])
				led_q <= sub_wr.wdata[9:8];
		end
	end

	assign flag_word = {flag_main_q, flag_sub_q};

	// main side read map
	always_comb
	begin
		if (main_ofs == `MCD_OFS_CTRL)
			main_map = {14'd0, sbrq_q, sres_q};
		else if (main_ofs == `MCD_OFS_HINT)
			main_map = hint_q;
		else if (main_ofs == `MCD_OFS_FLAG)
			main_map = flag_word;
		else if (cmd_hit[0])
			main_map = cmd_rdata[0];
		else if (sta_hit[0])
			main_map = sta_rdata[0];
		else
			main_map = `MCD_MAIN_UNMAPPED;
	end

	// sub side read map
	always_comb
	begin
		if (sub_ofs == `MCD_OFS_LED)
			sub_map = {6'd0, led_q, 8'd0};
		else if (sub_ofs == `MCD_OFS_FLAG)
			sub_map = flag_word;
		else if (cmd_hit[1])
			sub_map = cmd_rdata[1];
		else if (sta_hit[1])
			sub_map = sta_rdata[1];
		else
			sub_map = `MCD_SUB_UNMAPPED;
	end

	// read data one clock behind the offset
	always_ff @(posedge clk_asic)
	begin
		main_rdata <= main_map;
		sub_rdata  <= sub_map;
	end

	assign ctrl = '{sub_reset: ~sres_q, sub_bus_req: sbrq_q, irq2: irq2_q};
	assign led  = led_q;
	assign hint = hint_q;

endmodule

//--- verilog/mcd_comm.sv
`include "mcd_config.svh"

module mcd_comm
(
	input  logic               clk_asic,
	input  logic               cd_rst,
	input  logic               cd_halt,
	input  mcd_pkg::mcd_bus_t  main_bus,
	input  mcd_pkg::mcd_bus_t  sub_bus,
	output mcd_pkg::mcd_word_t main_rdata,
	output mcd_pkg::mcd_word_t sub_rdata,
	output mcd_pkg::mcd_ctrl_t ctrl,
	output logic [1:0]         led,
	output mcd_pkg::mcd_word_t hint
);
	import mcd_pkg::*;

	logic            sub_sync;
	mcd_wr_t         main_wr;
	mcd_wr_t         sub_wr;
	logic [1:0]      cmd_hit;      // [0] at main offset, [1] at sub offset
	mcd_word_t [1:0] cmd_rdata;
	logic [1:0]      sta_hit;
	mcd_word_t [1:0] sta_rdata;

	mcd_sub_clk_en i_clk_en
	(
		.clk_asic (clk_asic),
		.cd_rst   (cd_rst),
		.cd_halt  (cd_halt),
		.sub_sync (sub_sync)
	);

	mcd_bus_port i_main_port
	(
		.clk_asic (clk_asic),
		.cd_rst   (cd_rst),
		.sub_sync (sub_sync),
		.bus      (main_bus),
		.wr       (main_wr)
	);

	mcd_bus_port i_sub_port
	(
		.clk_asic (clk_asic),
		.cd_rst   (cd_rst),
		.sub_sync (sub_sync),
		.bus      (sub_bus),
		.wr       (sub_wr)
	);

	// command words, main writes, one copy per read offset
	mcd_com_bank #(.BASE(`MCD_OFS_CMD_BASE)) i_cmd_main
	(
		.clk_asic (clk_asic),
		.cd_rst   (cd_rst),
		.wr       (main_wr),
		.rd_ofs   (main_bus.ofs),
		.hit      (cmd_hit[0]),
		.rdata    (cmd_rdata[0])
	);

	mcd_com_bank #(.BASE(`MCD_OFS_CMD_BASE)) i_cmd_sub
	(
		.clk_asic (clk_asic),
		.cd_rst   (cd_rst),
		.wr       (main_wr),
		.rd_ofs   (sub_bus.ofs),
		.hit      (cmd_hit[1]),
		.rdata    (cmd_rdata[1])
	);

	// status words, sub writes
	mcd_com_bank #(.BASE(`MCD_OFS_STA_BASE)) i_sta_main
	(
		.clk_asic (clk_asic),
		.cd_rst   (cd_rst),
		.wr       (sub_wr),
		.rd_ofs   (main_bus.ofs),
		.hit      (sta_hit[0]),
		.rdata    (sta_rdata[0])
	);

	mcd_com_bank #(.BASE(`MCD_OFS_STA_BASE)) i_sta_sub
	(
		.clk_asic (clk_asic),
		.cd_rst   (cd_rst),
		.wr       (sub_wr),
		.rd_ofs   (sub_bus.ofs),
		.hit      (sta_hit[1]),
		.rdata    (sta_rdata[1])
	);

	mcd_gate_regs i_regs
	(
		.clk_asic   (clk_asic),
		.cd_rst     (cd_rst),
		.main_wr    (main_wr),
		.sub_wr     (sub_wr),
		.main_ofs   (main_bus.ofs),
		.sub_ofs    (sub_bus.ofs),
		.cmd_hit    (cmd_hit),
		.cmd_rdata  (cmd_rdata),
		.sta_hit    (sta_hit),
		.sta_rdata  (sta_rdata),
		.main_rdata (main_rdata),
		.sub_rdata  (sub_rdata),
		.ctrl       (ctrl),
		.led        (led),
		.hint       (hint)
	);

endmodule

//--- verif/mcd_comm_tb.sv
`include "mcd_config.svh"

module mcd_comm_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import mcd_pkg::*;

	localparam int SIDE_NONE = 0;    // read only row
	localparam int SIDE_MAIN = 1;
	localparam int SIDE_SUB  = 2;

	typedef struct
	{
		string      name;
		int         side;
		mcd_ofs_t   ofs;
		mcd_word_t  data;
		logic [1:0] lanes;
		bit         halt;        // write issued with cd_halt high
		mcd_word_t  exp_hold;    // main read while halted
		mcd_word_t  exp_main;
		mcd_word_t  exp_sub;
		mcd_word_t  exp_hint;
		mcd_ctrl_t  exp_ctrl;
		logic [1:0] exp_led;
		int         exp_irq;
	} row_t;

	logic       clk_asic;
	logic       cd_rst;
	logic       cd_halt;
	mcd_bus_t   main_bus;
	mcd_bus_t   sub_bus;
	mcd_word_t  main_rdata;
	mcd_word_t  sub_rdata;
	mcd_ctrl_t  ctrl;
	logic [1:0] led;
	mcd_word_t  hint;

	row_t       rows [$];
	integer     seed = 53;
	int         cycles = 0;
	int         limit = 0;
	int         irq_pulses = 0;

	// reference state of the register file
	mcd_word_t  cmd_m [`MCD_COM_WORDS];
	mcd_word_t  sta_m [`MCD_COM_WORDS];
	logic [7:0] flag_hi_m;
	logic [7:0] flag_lo_m;
	logic       sres_m;
	logic       sbrq_m;
	mcd_word_t  hint_m;
	logic [1:0] led_m;

	mcd_comm i_dut
	(
		.clk_asic   (clk_asic),
		.cd_rst     (cd_rst),
		.cd_halt    (cd_halt),
		.main_bus   (main_bus),
		.sub_bus    (sub_bus),
		.main_rdata (main_rdata),
		.sub_rdata  (sub_rdata),
		.ctrl       (ctrl),
		.led        (led),
		.hint       (hint)
	);

	initial
	begin
		clk_asic = 1'b0;
		forever #4 clk_asic = ~clk_asic;
	end

	always @(posedge clk_asic)
	begin
		cycles = cycles + 1;
		if (limit != 0 && cycles >= limit)
			abort_run($sformatf("timeout, no progress after %0d clock cycles", cycles));
	end

	// irq2 is sampled mid cycle
	always @(negedge clk_asic)
	begin
		if (ctrl.irq2)
			irq_pulses = irq_pulses + 1;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input mcd_word_t exp, input mcd_word_t act);
		if (act !== exp)
			abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_ctrl(input string name, input mcd_ctrl_t exp, input mcd_ctrl_t act);
		if (act !== exp)
			abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_led(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp)
			abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_pulses(input string name, input int exp, input int act);
		if (act != exp)
			abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
	endtask

	function automatic mcd_bus_t pack_bus(input mcd_ofs_t ofs, input mcd_word_t data,
		input logic [1:0] lanes);
		mcd_bus_t b;
		b.ofs   = ofs;
		b.wdata = data;
		b.we_lo = lanes[0];
		b.we_hi = lanes[1];
		b.ce    = |lanes;    // select only while a strobe is up
		return b;
	endfunction

	function automatic mcd_word_t merge_lanes(input mcd_word_t old, input mcd_word_t data,
		input logic [1:0] lanes);
		mcd_word_t res;
		res = old;
		if (lanes[0])
			res[7:0] = data[7:0];
		if (lanes[1])
			res[15:8] = data[15:8];
		return res;
	endfunction

	function automatic bit in_bank(input mcd_ofs_t ofs, input mcd_ofs_t base);
		return ofs >= base && ofs < base + 2 * `MCD_COM_WORDS;
	endfunction

	function automatic mcd_word_t main_view(input mcd_ofs_t ofs);
		if (ofs == `MCD_OFS_CTRL)
			return {14'd0, sbrq_m, sres_m};
		if (ofs == `MCD_OFS_HINT)
			return hint_m;
		if (ofs == `MCD_OFS_FLAG)
			return {flag_hi_m, flag_lo_m};
		if (in_bank(ofs, `MCD_OFS_CMD_BASE))
			return cmd_m[(ofs - `MCD_OFS_CMD_BASE) >> 1];
		if (in_bank(ofs, `MCD_OFS_STA_BASE))
			return sta_m[(ofs - `MCD_OFS_STA_BASE) >> 1];
		return `MCD_MAIN_UNMAPPED;
	endfunction

	function automatic mcd_word_t sub_view(input mcd_ofs_t ofs);
		if (ofs == `MCD_OFS_LED)
			return {6'd0, led_m, 8'd0};
		if (ofs == `MCD_OFS_FLAG)
			return {flag_hi_m, flag_lo_m};
		if (in_bank(ofs, `MCD_OFS_CMD_BASE))
			return cmd_m[(ofs - `MCD_OFS_CMD_BASE) >> 1];
		if (in_bank(ofs, `MCD_OFS_STA_BASE))
			return sta_m[(ofs - `MCD_OFS_STA_BASE) >> 1];
		return `MCD_SUB_UNMAPPED;
	endfunction

	task automatic model_write(input int side, input mcd_ofs_t ofs, input mcd_word_t data,
		input logic [1:0] lanes);
		if (side == SIDE_MAIN)
		begin
			if (ofs == `MCD_OFS_CTRL && lanes[0])
			begin
				sres_m = data[0];
				sbrq_m = data[1];
			end
			if (ofs == `MCD_OFS_HINT)
				hint_m = merge_lanes(hint_m, data, lanes);
			if (ofs == `MCD_OFS_FLAG)
				flag_hi_m = data[15:8];    // main owns the high byte
			if (in_bank(ofs, `MCD_OFS_CMD_BASE))
				cmd_m[(ofs - `MCD_OFS_CMD_BASE) >> 1] =
					merge_lanes(cmd_m[(ofs - `MCD_OFS_CMD_BASE) >> 1], data, lanes);
		end
		else if (side == SIDE_SUB)
		begin
			if (ofs == `MCD_OFS_LED && lanes[1])
				led_m = data[9:8];
			if (ofs == `MCD_OFS_FLAG)
				flag_lo_m = data[7:0];
			if (in_bank(ofs, `MCD_OFS_STA_BASE))
				sta_m[(ofs - `MCD_OFS_STA_BASE) >> 1] =
					merge_lanes(sta_m[(ofs - `MCD_OFS_STA_BASE) >> 1], data, lanes);
		end
	endtask

	task automatic add_row(input string name, input int side, input mcd_ofs_t ofs,
		input mcd_word_t data, input logic [1:0] lanes, input bit halt);
		row_t r;
		r.name     = name;
		r.side     = side;
		r.ofs      = ofs;
		r.data     = data;
		r.lanes    = lanes;
		r.halt     = halt;
		r.exp_hold = main_view(ofs);
		r.exp_irq  = (side == SIDE_MAIN && ofs == `MCD_OFS_CTRL && lanes[1] && data[8]) ? 1 : 0;
		model_write(side, ofs, data, lanes);
		r.exp_main = main_view(ofs);
		r.exp_sub  = sub_view(ofs);
		r.exp_hint = hint_m;
		r.exp_ctrl = '{sub_reset: ~sres_m, sub_bus_req: sbrq_m, irq2: 1'b0};
		r.exp_led  = led_m;
		rows.push_back(r);
	endtask

	function automatic mcd_word_t rand_word();
		return mcd_word_t'($random(seed));
	endfunction

	task automatic build_table();
		for (int i = 0; i < `MCD_COM_WORDS; i++)
		begin
			cmd_m[i] = '0;
			sta_m[i] = '0;
		end
		flag_hi_m = 8'h00;
		flag_lo_m = 8'h00;
		sres_m    = 1'b0;
		sbrq_m    = 1'b0;
		hint_m    = `MCD_HINT_RESET;
		led_m     = 2'b00;
		add_row("reset hint", SIDE_NONE, `MCD_OFS_HINT, '0, 2'b00, 0);
		add_row("reset ctrl", SIDE_NONE, `MCD_OFS_CTRL, '0, 2'b00, 0);
		for (int i = 0; i < `MCD_COM_WORDS; i++)
			add_row($sformatf("cmd write %0d", i), SIDE_MAIN,
				mcd_ofs_t'(`MCD_OFS_CMD_BASE + 2 * i), rand_word(), 2'b11, 0);
		add_row("sub to cmd", SIDE_SUB, `MCD_OFS_CMD_BASE + 9'd2, rand_word(), 2'b11, 0);
		for (int i = 0; i < `MCD_COM_WORDS; i++)
			add_row($sformatf("sta write %0d", i), SIDE_SUB,
				mcd_ofs_t'(`MCD_OFS_STA_BASE + 2 * i), rand_word(), i[0] ? 2'b10 : 2'b01, 0);
		add_row("flag main", SIDE_MAIN, `MCD_OFS_FLAG, rand_word(), 2'b11, 0);
		add_row("flag sub", SIDE_SUB, `MCD_OFS_FLAG, rand_word(), 2'b11, 0);
		add_row("hint write", SIDE_MAIN, `MCD_OFS_HINT, rand_word(), 2'b10, 0);
		add_row("ctrl run", SIDE_MAIN, `MCD_OFS_CTRL, 16'h0003, 2'b01, 0);
		add_row("irq2 trigger", SIDE_MAIN, `MCD_OFS_CTRL, 16'h0100, 2'b10, 0);
		add_row("led write", SIDE_SUB, `MCD_OFS_LED, rand_word() | 16'h0100, 2'b11, 0);
		add_row("halted cmd", SIDE_MAIN, `MCD_OFS_CMD_BASE + 9'd6, rand_word(), 2'b11, 1);
		add_row("unmapped 040", SIDE_NONE, 9'h040, '0, 2'b00, 0);
		add_row("unmapped 008", SIDE_NONE, 9'h008, '0, 2'b00, 0);
	endtask

	task automatic wait_clocks(input int n);
		repeat (n) @(negedge clk_asic);
	endtask

	task automatic run_row(input row_t r);
		@(negedge clk_asic);
		irq_pulses = 0;
		main_bus   = pack_bus(r.ofs, '0, 2'b00);    // offset doubles as read address
		sub_bus    = pack_bus(r.ofs, '0, 2'b00);
		if (r.side != SIDE_NONE)
		begin
			cd_halt = r.halt;
			if (r.side == SIDE_MAIN)
				main_bus = pack_bus(r.ofs, r.data, r.lanes);
			else
				sub_bus = pack_bus(r.ofs, r.data, r.lanes);
			wait_clocks(12);
			if (r.halt)
			begin
				check_word({r.name, " while halted"}, r.exp_hold, main_rdata);
				cd_halt = 1'b0;    // strobe still held so the write lands now
				wait_clocks(12);
			end
			main_bus = pack_bus(r.ofs, '0, 2'b00);
			sub_bus  = pack_bus(r.ofs, '0, 2'b00);
			wait_clocks(8);
		end
		wait_clocks(2);
		check_word({r.name, " main read"}, r.exp_main, main_rdata);
		check_word({r.name, " sub read"}, r.exp_sub, sub_rdata);
		check_word({r.name, " hint"}, r.exp_hint, hint);
		check_ctrl({r.name, " ctrl"}, r.exp_ctrl, ctrl);
		check_led({r.name, " led"}, r.exp_led, led);
		check_pulses({r.name, " irq2 pulses"}, r.exp_irq, irq_pulses);
	endtask

	initial
	begin
		cd_rst   = 1'b1;
		cd_halt  = 1'b0;
		main_bus = pack_bus('0, '0, 2'b00);
		sub_bus  = pack_bus('0, '0, 2'b00);
		build_table();
		limit = rows.size() * 24 + 100;
		wait_clocks(5);
		cd_rst = 1'b0;
		for (int i = 0; i < rows.size(); i++)
			run_row(rows[i]);
		$display("test passed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+include
verilog/mcd_pkg.sv
verilog/mcd_sub_clk_en.sv
verilog/mcd_bus_port.sv
verilog/mcd_com_bank.sv
verilog/mcd_gate_regs.sv
verilog/mcd_comm.sv
verif/mcd_comm_tb.sv
